//--- logic/fsab_pkg.sv
// FSAB request bus definitions shared by every block on the bus.
package fsab_pkg;

	// Field widths of one request beat.
	localparam int DID_W = 4;
	localparam int ADDR_W = 8;
	localparam int LEN_W = 3;
	localparam int DATA_W = 32;
	localparam int MASK_W = 4;

	// Request opcode.
	typedef enum logic [0:0] {
		MODE_READ = 1'b0,
		MODE_WRITE = 1'b1
	} fsab_mode_e;

	// One beat on the request bus.
	// Addr and len are only meaningful on the first beat of a transaction.
	// A write carries len beats and a read is always a single beat.
	typedef struct packed {
		fsab_mode_e mode;
		logic [DID_W-1:0] did;
		logic [DID_W-1:0] subdid;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0] len;
		logic [DATA_W-1:0] data;
		logic [MASK_W-1:0] mask;
	} fsab_req_t;

endpackage

//--- logic/fsab_arb_pkg.sv
// Types internal to the arbiter and the completion path.
package fsab_arb_pkg;

	// Per-device buffer state.
	typedef enum logic [1:0] {
		FIFO_IDLE = 2'd0,
		FIFO_READY = 2'd1,
		FIFO_SEND = 2'd2
	} fifo_state_e;

	// One finished transaction as reported by the target.
	// Data is the read word, or zero for a write.
	typedef struct packed {
		fsab_pkg::fsab_mode_e mode;
		logic [fsab_pkg::DID_W-1:0] did;
		logic [fsab_pkg::DID_W-1:0] subdid;
		logic [fsab_pkg::ADDR_W-1:0] addr;
		logic [fsab_pkg::DATA_W-1:0] data;
	} fsab_cpl_t;

endpackage

//--- logic/fsab_arbiter_fifo.sv
`timescale 1ns/10ps

// Beat buffer for one requesting device.
// Holds beats until the head transaction is complete, then replays it on start.
module fsab_arbiter_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_b,
	input logic inp_valid,
	input fsab_pkg::fsab_req_t inp_req,
	input logic start,
	output logic inp_credit,
	output logic ready,
	output logic active,
	output fsab_pkg::fsab_req_t out_req,
	output logic out_valid
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	fsab_pkg::fsab_req_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [fsab_pkg::LEN_W-1:0] beats_left;
	logic [fsab_pkg::LEN_W-1:0] head_beats;
	logic head_complete;
	logic push;
	logic pop;
	fsab_arb_pkg::fifo_state_e state;
	fsab_arb_pkg::fifo_state_e state_next;

	assign out_req = mem[rd_ptr];

	// Reads are one beat, writes carry len beats.
	assign head_beats = (out_req.mode == fsab_pkg::MODE_WRITE) ?
		out_req.len : fsab_pkg::LEN_W'(1);
	assign head_complete = (count != '0) && (int'(count) >= int'(head_beats));

	assign active = (state == fsab_arb_pkg::FIFO_SEND);
	// Head beat present. The arbiter qualifies it with active.
	assign out_valid = (count != '0);
	assign ready = head_complete && !active;

	assign push = inp_valid;
	assign pop = active && out_valid;

	// Every beat that leaves for the bus frees one slot for the device.
	assign inp_credit = pop;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= inp_req;
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (int'(wr_ptr) == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (int'(rd_ptr) == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	always_comb begin
		state_next = state;
		unique case (state)
			fsab_arb_pkg::FIFO_IDLE: begin
				if (start)
					state_next = fsab_arb_pkg::FIFO_SEND;
				else if (head_complete)
					state_next = fsab_arb_pkg::FIFO_READY;
			end
			fsab_arb_pkg::FIFO_READY: begin
				if (start)
					state_next = fsab_arb_pkg::FIFO_SEND;
			end
			fsab_arb_pkg::FIFO_SEND: begin
				// Last beat goes out this cycle.
				if (beats_left == fsab_pkg::LEN_W'(1))
					state_next = fsab_arb_pkg::FIFO_IDLE;
			end
			default: state_next = fsab_arb_pkg::FIFO_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state <= fsab_arb_pkg::FIFO_IDLE;
			beats_left <= '0;
		end else begin
			state <= state_next;
			if (start)
				beats_left <= head_beats;
			else if (pop)
				beats_left <= beats_left - 1'b1;
		end
	end

	// The device must respect its credits, so a full buffer never sees a beat.
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_b)
		inp_valid |-> (int'(count) < FIFO_DEPTH))
		else $error("fifo: write into full buffer");

	a_start_ready: assert property (@(posedge clk) disable iff (!rst_b)
		start |-> ready)
		else $error("fifo: start without a complete transaction");

endmodule

//--- logic/fsab_arbiter.sv
`timescale 1ns/10ps

// Request arbiter.
// One buffer per device, fixed priority selection and one outbound bus.
module fsab_arbiter #(
	parameter int DEVICES = 3,
	parameter int FIFO_DEPTH = 8,
	parameter int OUT_CREDITS = 2
) (
	input logic clk,
	input logic rst_b,
	input logic [DEVICES-1:0] dev_valid,
	input fsab_pkg::fsab_req_t dev_req [DEVICES],
	input logic out_credit,
	output logic [DEVICES-1:0] dev_credit,
	output logic bus_valid,
	output fsab_pkg::fsab_req_t bus_req
);

	localparam int SEL_W = (DEVICES > 1) ? $clog2(DEVICES) : 1;
	localparam int CRED_W = $clog2(OUT_CREDITS + 1);

	fsab_pkg::fsab_req_t fifo_req [DEVICES];
	logic [DEVICES-1:0] fifo_valid;
	logic [DEVICES-1:0] fifo_ready;
	logic [DEVICES-1:0] fifo_active;
	logic [DEVICES-1:0] fifo_start;

	logic [CRED_W-1:0] credits;
	logic credit_avail;
	logic [SEL_W-1:0] cur_dev;
	logic [SEL_W-1:0] next_dev;
	logic new_selection;

	for (genvar i = 0; i < DEVICES; i++) begin : g_fifo
		fsab_arbiter_fifo #(
			.FIFO_DEPTH(FIFO_DEPTH)
		) u_fifo (
			.clk(clk),
			.rst_b(rst_b),
			.inp_valid(dev_valid[i]),
			.inp_req(dev_req[i]),
			.start(fifo_start[i]),
			.inp_credit(dev_credit[i]),
			.ready(fifo_ready[i]),
			.active(fifo_active[i]),
			.out_req(fifo_req[i]),
			.out_valid(fifo_valid[i])
		);
	end

	// Outbound credits, one per transaction in flight at the target.
	assign credit_avail = (credits != '0);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			credits <= CRED_W'(OUT_CREDITS);
		else
			credits <= credits + CRED_W'(out_credit) - CRED_W'(|fifo_start);
	end

	// Highest numbered ready device wins.
	always_comb begin
		next_dev = '0;
		for (int i = 0; i < DEVICES; i++)
			if (fifo_ready[i])
				next_dev = SEL_W'(i);
	end

	// Only the current device can be active, so this covers the whole bus.
	assign new_selection = !fifo_active[cur_dev];

	always_comb begin
		fifo_start = '0;
		if (new_selection && credit_avail && fifo_ready[next_dev])
			fifo_start[next_dev] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			cur_dev <= '0;
		else if (|fifo_start)
			cur_dev <= next_dev;
	end

	// Mask stale beats from a buffer that is no longer driving.
	assign bus_valid = fifo_valid[cur_dev] & fifo_active[cur_dev];
	assign bus_req = fifo_req[cur_dev];

	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_b)
		credits <= CRED_W'(OUT_CREDITS))
		else $error("arbiter: outbound credit count out of range");

	// The target only returns credits that were spent.
	a_credit_return: assert property (@(posedge clk) disable iff (!rst_b)
		out_credit |-> ((credits < CRED_W'(OUT_CREDITS)) || (|fifo_start)))
		else $error("arbiter: credit returned beyond the initial count");

	a_one_active: assert property (@(posedge clk) disable iff (!rst_b)
		$onehot0(fifo_active))
		else $error("arbiter: more than one buffer active");

endmodule

//--- logic/fsab_mem_target.sv
`timescale 1ns/10ps

// Word memory on the request bus.
// Applies masked multi-beat writes, answers single beat reads.
module fsab_mem_target #(
	parameter int MEM_WORDS = 256
) (
	input logic clk,
	input logic rst_b,
	input logic bus_valid,
	input fsab_pkg::fsab_req_t bus_req,
	output logic out_credit,
	output logic cpl_valid,
	output fsab_arb_pkg::fsab_cpl_t cpl
);

	localparam int MEM_AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [fsab_pkg::DATA_W-1:0] mem [MEM_WORDS];
	logic [fsab_pkg::LEN_W-1:0] beats_left;
	logic [fsab_pkg::ADDR_W-1:0] wr_addr;
	logic [MEM_AW-1:0] wr_idx;
	logic is_hdr;
	logic is_write;
	logic wr_en;
	logic done;

	// Any beat while no write is open starts a new transaction.
	assign is_hdr = bus_valid && (beats_left == '0);
	assign is_write = (bus_req.mode == fsab_pkg::MODE_WRITE);
	assign wr_en = bus_valid && (!is_hdr || is_write);
	assign wr_idx = is_hdr ? MEM_AW'(bus_req.addr) : MEM_AW'(wr_addr);
	assign done = is_hdr ? (!is_write || (bus_req.len <= fsab_pkg::LEN_W'(1))) :
		(bus_valid && (beats_left == fsab_pkg::LEN_W'(1)));

	always_ff @(posedge clk) begin
		if (wr_en)
			for (int b = 0; b < fsab_pkg::MASK_W; b++)
				if (bus_req.mask[b])
					mem[wr_idx][b*8 +: 8] <= bus_req.data[b*8 +: 8];
	end

	// Header and read data; held until the completion goes out.
	always_ff @(posedge clk) begin
		if (is_hdr) begin
			cpl.mode <= bus_req.mode;
			cpl.did <= bus_req.did;
			cpl.subdid <= bus_req.subdid;
			cpl.addr <= bus_req.addr;
			cpl.data <= is_write ? '0 : mem[MEM_AW'(bus_req.addr)];
			wr_addr <= bus_req.addr + 1'b1;
		end else if (wr_en) begin
			wr_addr <= wr_addr + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			beats_left <= '0;
			cpl_valid <= 1'b0;
			out_credit <= 1'b0;
		end else begin
			if (is_hdr && is_write && (bus_req.len > fsab_pkg::LEN_W'(1)))
				beats_left <= bus_req.len - 1'b1;
			else if (!is_hdr && bus_valid)
				beats_left <= beats_left - 1'b1;
			cpl_valid <= done;
			out_credit <= done;
		end
	end

	// Write data beats must come from the device that opened the write.
	a_no_interleave: assert property (@(posedge clk) disable iff (!rst_b)
		(bus_valid && (beats_left != '0)) |-> (bus_req.did == cpl.did))
		else $error("target: new header while write beats remain");

endmodule

//--- logic/fsab_fabric.sv
`timescale 1ns/10ps

// Request fabric top.
// Devices feed the arbiter, which drives the memory target.
module fsab_fabric #(
	parameter int DEVICES = 3,
	parameter int FIFO_DEPTH = 8,
	parameter int OUT_CREDITS = 2,
	parameter int MEM_WORDS = 256
) (
	input logic clk,
	input logic rst_b,
	input logic [DEVICES-1:0] dev_valid,
	input fsab_pkg::fsab_req_t dev_req [DEVICES],
	output logic [DEVICES-1:0] dev_credit,
	output logic cpl_valid,
	output fsab_arb_pkg::fsab_cpl_t cpl
);

	logic bus_valid;
	fsab_pkg::fsab_req_t bus_req;
	logic out_credit;

	fsab_arbiter #(
		.DEVICES(DEVICES),
		.FIFO_DEPTH(FIFO_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) u_fsab_arbiter (
		.clk(clk),
		.rst_b(rst_b),
		.dev_valid(dev_valid),
		.dev_req(dev_req),
		.out_credit(out_credit),
		.dev_credit(dev_credit),
		.bus_valid(bus_valid),
		.bus_req(bus_req)
	);

	fsab_mem_target #(
		.MEM_WORDS(MEM_WORDS)
	) u_fsab_mem_target (
		.clk(clk),
		.rst_b(rst_b),
		.bus_valid(bus_valid),
		.bus_req(bus_req),
		.out_credit(out_credit),
		.cpl_valid(cpl_valid),
		.cpl(cpl)
	);

endmodule

//--- dv/fsab_checker.sv
`timescale 1ns/10ps

// Watches device beats going into the fabric and completions coming out.
// Read data is predicted from a reference memory built from the device writes.
module fsab_checker #(
	parameter int DEVICES = 3,
	parameter int MEM_WORDS = 256
) (
	input logic clk,
	input logic rst_b,
	input logic [DEVICES-1:0] dev_valid,
	input fsab_pkg::fsab_req_t dev_req [DEVICES],
	input logic cpl_valid,
	input fsab_arb_pkg::fsab_cpl_t cpl,
	output int completed,
	output int passed,
	output int errors
);

	fsab_arb_pkg::fsab_cpl_t exp_q[$];
	logic [fsab_pkg::DATA_W-1:0] ref_mem [MEM_WORDS];
	int beats_left [DEVICES];
	logic [fsab_pkg::ADDR_W-1:0] next_addr [DEVICES];

	// A beat with no write open is a header and adds one expected completion.
	task automatic take_beat(input int d, input fsab_pkg::fsab_req_t b);
		fsab_arb_pkg::fsab_cpl_t e;
		logic [fsab_pkg::ADDR_W-1:0] a;
		if (beats_left[d] == 0) begin
			a = b.addr;
			e.mode = b.mode;
			e.did = b.did;
			e.subdid = b.subdid;
			e.addr = b.addr;
			e.data = (b.mode == fsab_pkg::MODE_WRITE) ? '0 : ref_mem[b.addr];
			exp_q.push_back(e);
			beats_left[d] = (b.mode == fsab_pkg::MODE_WRITE) ? int'(b.len) - 1 : 0;
			next_addr[d] = b.addr + 1'b1;
		end else begin
			a = next_addr[d];
			next_addr[d] = next_addr[d] + 1'b1;
			beats_left[d] = beats_left[d] - 1;
		end
		if (b.mode == fsab_pkg::MODE_WRITE)
			for (int i = 0; i < fsab_pkg::MASK_W; i++)
				if (b.mask[i])
					ref_mem[a][i*8 +: 8] = b.data[i*8 +: 8];
	endtask

	// Oldest outstanding entry of the same device must match.
	task automatic check_cpl(input fsab_arb_pkg::fsab_cpl_t c);
		int idx;
		idx = -1;
		for (int i = 0; i < exp_q.size(); i++)
			if (idx < 0 && exp_q[i].did == c.did)
				idx = i;
		if (idx < 0) begin
			errors++;
			$display("Completion from device %0d arrived with nothing outstanding", c.did);
		end else begin
			completed++;
			if (c !== exp_q[idx]) begin
				errors++;
				$display("MISMATCH at %0t: dev %0d got subdid %0d mode %0d addr %h data %h",
					$time, c.did, c.subdid, c.mode, c.addr, c.data);
				$display("  expected subdid %0d mode %0d addr %h data %h",
					exp_q[idx].subdid, exp_q[idx].mode, exp_q[idx].addr, exp_q[idx].data);
			end else begin
				passed++;
				$display("ok at %0t: dev %0d subdid %0d mode %0d addr %h data %h",
					$time, c.did, c.subdid, c.mode, c.addr, c.data);
			end
			exp_q.delete(idx);
		end
	endtask

	always @(posedge clk) begin
		if (!rst_b) begin
			completed = 0;
			passed = 0;
			errors = 0;
			for (int d = 0; d < DEVICES; d++)
				beats_left[d] = 0;
		end else begin
			for (int d = 0; d < DEVICES; d++)
				if (dev_valid[d])
					take_beat(d, dev_req[d]);
			if (cpl_valid)
				check_cpl(cpl);
		end
	end

endmodule

//--- dv/fsab_fabric_tb.sv
`timescale 1ns/10ps

module fsab_fabric_tb;

	localparam int DEVICES = 3;
	localparam int FIFO_DEPTH = 8;
	localparam int OUT_CREDITS = 2;
	localparam int MEM_WORDS = 256;
	localparam fsab_pkg::fsab_mode_e WR = fsab_pkg::MODE_WRITE;
	localparam fsab_pkg::fsab_mode_e RD = fsab_pkg::MODE_READ;

	// One table row is one transaction.
	typedef struct packed {
		logic [1:0] dev;
		fsab_pkg::fsab_mode_e mode;
		logic [fsab_pkg::DID_W-1:0] subdid;
		logic [fsab_pkg::ADDR_W-1:0] addr;
		logic [fsab_pkg::LEN_W-1:0] len;
		logic [fsab_pkg::DATA_W-1:0] data;
		logic [fsab_pkg::MASK_W-1:0] mask;
	} row_t;

	logic clk;
	logic rst_b;
	logic [DEVICES-1:0] dev_valid;
	fsab_pkg::fsab_req_t dev_req [DEVICES];
	logic [DEVICES-1:0] dev_credit;
	logic cpl_valid;
	fsab_arb_pkg::fsab_cpl_t cpl;

	row_t rows[$];
	int gaps[$];
	int credits [DEVICES];
	logic [15:0] lfsr;
	int total_beats;
	int limit;
	int cycle_count;
	int errors;
	int completed;
	int passed;
	int chk_errors;

	fsab_fabric #(
		.DEVICES(DEVICES),
		.FIFO_DEPTH(FIFO_DEPTH),
		.OUT_CREDITS(OUT_CREDITS),
		.MEM_WORDS(MEM_WORDS)
	) u_fsab_fabric (
		.clk(clk),
		.rst_b(rst_b),
		.dev_valid(dev_valid),
		.dev_req(dev_req),
		.dev_credit(dev_credit),
		.cpl_valid(cpl_valid),
		.cpl(cpl)
	);

	fsab_checker #(
		.DEVICES(DEVICES),
		.MEM_WORDS(MEM_WORDS)
	) u_checker (
		.clk(clk),
		.rst_b(rst_b),
		.dev_valid(dev_valid),
		.dev_req(dev_req),
		.cpl_valid(cpl_valid),
		.cpl(cpl),
		.completed(completed),
		.passed(passed),
		.errors(chk_errors)
	);

	always #2 clk = ~clk;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken.
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic void add_row(input int dev, input fsab_pkg::fsab_mode_e mode,
		input int subdid, input logic [7:0] addr, input int len,
		input logic [31:0] data, input logic [3:0] mask);
		row_t r;
		r.dev = 2'(dev);
		r.mode = mode;
		r.subdid = fsab_pkg::DID_W'(subdid);
		r.addr = addr;
		r.len = fsab_pkg::LEN_W'(len);
		r.data = data;
		r.mask = mask;
		rows.push_back(r);
	endfunction

	// Each device works in its own address window.
	function automatic void build_table();
		add_row(0, WR, 1, 8'h10, 4, 32'h1000_0000, 4'hf);
		add_row(0, WR, 2, 8'h12, 1, 32'haabb_ccdd, 4'b0101);
		add_row(0, RD, 3, 8'h12, 1, 32'h0, 4'h0);
		add_row(0, RD, 4, 8'h13, 1, 32'h0, 4'h0);
		add_row(0, WR, 5, 8'h14, 7, 32'h2000_0000, 4'hf);
		add_row(0, WR, 6, 8'h1b, 3, 32'h3000_0000, 4'hf);
		add_row(0, RD, 7, 8'h1a, 1, 32'h0, 4'h0);
		add_row(1, WR, 1, 8'h40, 2, 32'h4444_0000, 4'hf);
		add_row(1, WR, 2, 8'h41, 1, 32'h5566_7788, 4'b1000);
		add_row(1, RD, 3, 8'h41, 1, 32'h0, 4'h0);
		add_row(1, RD, 4, 8'h40, 1, 32'h0, 4'h0);
		add_row(1, WR, 5, 8'h42, 5, 32'h6000_0010, 4'hf);
		add_row(1, RD, 6, 8'h46, 1, 32'h0, 4'h0);
		add_row(2, WR, 1, 8'h80, 3, 32'h8000_0000, 4'hf);
		add_row(2, WR, 2, 8'h80, 1, 32'h1234_5678, 4'b0011);
		add_row(2, RD, 3, 8'h80, 1, 32'h0, 4'h0);
		add_row(2, RD, 4, 8'h82, 1, 32'h0, 4'h0);
		add_row(2, WR, 5, 8'h83, 6, 32'h9000_0100, 4'hf);
		add_row(2, RD, 6, 8'h88, 1, 32'h0, 4'h0);
	endfunction

	function automatic fsab_pkg::fsab_req_t make_beat(input row_t r, input int k);
		fsab_pkg::fsab_req_t b;
		b.mode = r.mode;
		b.did = fsab_pkg::DID_W'(r.dev);
		b.subdid = r.subdid;
		b.addr = r.addr;
		b.len = r.len;
		b.data = r.data + 32'(k);
		b.mask = r.mask;
		return b;
	endfunction

	task automatic wait_cycle();
		@(posedge clk);
		#1;
	endtask

	// Sends this device's rows in table order, one beat per credit.
	task automatic drive_device(input int d);
		row_t r;
		int beats;
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			if (int'(r.dev) == d) begin
				repeat (gaps[i]) wait_cycle();
				beats = (r.mode == fsab_pkg::MODE_WRITE) ? int'(r.len) : 1;
				for (int k = 0; k < beats; k++) begin
					while (credits[d] == 0)
						wait_cycle();
					dev_req[d] = make_beat(r, k);
					dev_valid[d] = 1'b1;
					credits[d] = credits[d] - 1;
					wait_cycle();
					dev_valid[d] = 1'b0;
				end
			end
		end
	endtask

	always @(posedge clk) begin
		for (int d = 0; d < DEVICES; d++)
			if (rst_b && dev_credit[d]) begin
				credits[d] = credits[d] + 1;
				if (credits[d] > FIFO_DEPTH) begin
					errors++;
					$display("Device %0d received a credit it never spent", d);
				end
			end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (limit > 0 && cycle_count > limit) begin
			$display("Timeout: transactions still outstanding after %0d cycles", limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_b = 1'b0;
		dev_valid = '0;
		for (int d = 0; d < DEVICES; d++) begin
			dev_req[d] = '0;
			credits[d] = FIFO_DEPTH;
		end
		errors = 0;
		cycle_count = 0;
		limit = 0;
		total_beats = 0;
		lfsr = 16'd12703;
		build_table();
		for (int i = 0; i < rows.size(); i++) begin
			gaps.push_back(take_bits(2));
			total_beats += (rows[i].mode == fsab_pkg::MODE_WRITE) ? int'(rows[i].len) : 1;
		end
		limit = 20 * total_beats;
		repeat (3) @(posedge clk);
		#1;
		rst_b = 1'b1;
		fork
			drive_device(0);
			drive_device(1);
			drive_device(2);
		join
		while (completed < rows.size())
			@(posedge clk);
		// Room for a stray duplicate completion or credit.
		repeat (4) @(posedge clk);
		for (int d = 0; d < DEVICES; d++)
			if (credits[d] != FIFO_DEPTH) begin
				errors++;
				$display("Device %0d ended with %0d credits instead of %0d",
					d, credits[d], FIFO_DEPTH);
			end
		$display("Tests: %0d of %0d completed, %0d passed, %0d errors",
			completed, rows.size(), passed, errors + chk_errors);
		if (errors == 0 && chk_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- fsab_fabric.f
logic/fsab_pkg.sv
logic/fsab_arb_pkg.sv
logic/fsab_arbiter_fifo.sv
logic/fsab_arbiter.sv
logic/fsab_mem_target.sv
logic/fsab_fabric.sv
dv/fsab_checker.sv
dv/fsab_fabric_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fsab_fabric_tb -Mdir build -f fsab_fabric.f

./build/Vfsab_fabric_tb > sim.log 2>&1 || true
cat sim.log

grep -q "^STATUS: PASS$" sim.log
